// File: logic/alu_cluster.sv
`default_nettype none

module alu_cluster
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       flush_i,
    input  logic       disp_valid_i,
    input  unit_t      disp_unit_i,
    input  alu_op_e    disp_op_i,
    input  tag_t       disp_dst_i,
    input  tag_t       disp_src1_tag_i,
    input  word_t      disp_src1_val_i,
    input  logic       disp_src1_rdy_i,
    input  op2_field_u disp_op2_i,
    input  logic       disp_use_imm_i,
    input  word_t      disp_src2_val_i,
    input  logic       disp_src2_rdy_i,
    output logic       iq0_ready_o,
    output logic       iq1_ready_o,
    output logic       cdb_valid_o,
    output tag_t       cdb_tag_o,
    output word_t      cdb_data_o
);

    logic [1:0] req;
    logic [1:0] gnt;
    logic [1:0] iq_ready;
    tag_t       res_tag  [2];
    word_t      res_data [2];

    for (genvar q = 0; q < 2; q++) begin : g_iq
        issue_queue #(
            .QUEUE_ID (unit_t'(q))
        ) u_iq (
            .clk             (clk),
            .arst_n_i        (arst_n_i),
            .flush_i         (flush_i),
            .disp_valid_i    (disp_valid_i),
            .disp_unit_i     (disp_unit_i),
            .disp_op_i       (disp_op_i),
            .disp_dst_i      (disp_dst_i),
            .disp_src1_tag_i (disp_src1_tag_i),
            .disp_src1_val_i (disp_src1_val_i),
            .disp_src1_rdy_i (disp_src1_rdy_i),
            .disp_op2_i      (disp_op2_i),
            .disp_use_imm_i  (disp_use_imm_i),
            .disp_src2_val_i (disp_src2_val_i),
            .disp_src2_rdy_i (disp_src2_rdy_i),
            .ready_o         (iq_ready[q]),
            // cdb fed back into both queues
            .cdb_valid_i     (cdb_valid_o),
            .cdb_tag_i       (cdb_tag_o),
            .cdb_data_i      (cdb_data_o),
            .req_o           (req[q]),
            .gnt_i           (gnt[q]),
            .res_tag_o       (res_tag[q]),
            .res_data_o      (res_data[q])
        );
    end

    assign iq0_ready_o = iq_ready[0];
    assign iq1_ready_o = iq_ready[1];

    cdb_arbiter u_arb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .req_i       (req),
        .tag0_i      (res_tag[0]),
        .data0_i     (res_data[0]),
        .tag1_i      (res_tag[1]),
        .data1_i     (res_data[1]),
        .gnt_o       (gnt),
        .cdb_valid_o (cdb_valid_o),
        .cdb_tag_o   (cdb_tag_o),
        .cdb_data_o  (cdb_data_o)
    );

endmodule

`default_nettype wire

// File: logic/cdb_arbiter.sv
`default_nettype none

`include "core_macros.svh"

module cdb_arbiter (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               flush_i,
    input  logic [1:0]         req_i,
    input  logic [`TAG_W-1:0]  tag0_i,
    input  logic [`DATA_W-1:0] data0_i,
    input  logic [`TAG_W-1:0]  tag1_i,
    input  logic [`DATA_W-1:0] data1_i,
    output logic [1:0]         gnt_o,
    output logic               cdb_valid_o,
    output logic [`TAG_W-1:0]  cdb_tag_o,
    output logic [`DATA_W-1:0] cdb_data_o
);

    // set when queue 1 wins the next contested cycle
    logic prio_q;

    always_comb begin
        gnt_o = req_i;
        if (req_i == 2'b11) gnt_o = prio_q ? 2'b10 : 2'b01;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q      <= 1'b0;
            cdb_valid_o <= 1'b0;
        end else if (flush_i) begin
            prio_q      <= 1'b0;
            cdb_valid_o <= 1'b0;
        end else begin
            if (req_i == 2'b11) prio_q <= !prio_q;
            cdb_valid_o <= |gnt_o;
        end
    end

    // broadcast payload
    always_ff @(posedge clk) begin
        if (gnt_o[1]) begin
            cdb_tag_o  <= tag1_i;
            cdb_data_o <= data1_i;
        end else if (gnt_o[0]) begin
            cdb_tag_o  <= tag0_i;
            cdb_data_o <= data0_i;
        end
    end

    a_gnt_legal: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == 2'b00));

    // back-to-back contested cycles alternate the winner
    a_gnt_alternate: assert property (@(posedge clk) disable iff (!arst_n_i)
        (req_i == 2'b11) && !flush_i |=> (req_i != 2'b11) || (gnt_o != $past(gnt_o)));

endmodule

`default_nettype wire

// File: logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath widths

// operand and result width
`define DATA_W 16

// physical destination tag width
`define TAG_W 4

// queue sizing

// entries per issue queue
`define IQ_DEPTH 4

// one-hot saturating age width
`define AGE_W 4

`endif

// File: logic/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    // data value on operands, results and the cdb
    typedef logic [`DATA_W-1:0] word_t;

    // physical register tag
    typedef logic [`TAG_W-1:0] tag_t;

    // one-hot age where zero means newly allocated
    typedef logic [`AGE_W-1:0] age_t;

    // target queue of an instruction
    typedef logic unit_t;

endpackage

`default_nettype wire

// File: logic/int_alu.sv
`default_nettype none

module int_alu
    import core_pkg::*;
    import isa_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    // shift amount from the low bits of b
    logic [3:0] shamt;

    assign shamt = b_i[3:0];

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLL: result_o = a_i << shamt;
            ALU_SRL: result_o = a_i >> shamt;
            // signed compare giving 1 or 0
            ALU_SLT: result_o = word_t'($signed(a_i) < $signed(b_i));
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/iq_entry.sv
`default_nettype none

module iq_entry
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       flush_i,
    input  logic       alloc_i,
    input  alu_op_e    op_i,
    input  tag_t       dst_i,
    input  tag_t       src1_tag_i,
    input  word_t      src1_val_i,
    input  logic       src1_rdy_i,
    input  op2_field_u op2_i,
    input  logic       use_imm_i,
    input  word_t      src2_val_i,
    input  logic       src2_rdy_i,
    input  logic       issue_i,
    input  logic       cdb_valid_i,
    input  tag_t       cdb_tag_i,
    input  word_t      cdb_data_i,
    output logic       valid_o,
    output logic       ready_o,
    output alu_op_e    op_o,
    output tag_t       dst_o,
    output word_t      a_o,
    output word_t      b_o
);

    logic    valid_q;
    logic    a_rdy_q;
    logic    b_rdy_q;
    alu_op_e op_q;
    tag_t    dst_q;
    tag_t    a_tag_q;
    tag_t    b_tag_q;
    word_t   a_q;
    word_t   b_q;

    // bypass of a broadcast arriving on the dispatch edge
    logic    src1_hit;
    logic    src2_hit;
    // wake-up of an operand already waiting in the entry
    logic    a_hit;
    logic    b_hit;

    assign src1_hit = cdb_valid_i && !src1_rdy_i && (cdb_tag_i == src1_tag_i);
    assign src2_hit = cdb_valid_i && !use_imm_i && !src2_rdy_i
                      && (cdb_tag_i == op2_i.r.tag);
    assign a_hit    = cdb_valid_i && valid_q && !a_rdy_q && (cdb_tag_i == a_tag_q);
    assign b_hit    = cdb_valid_i && valid_q && !b_rdy_q && (cdb_tag_i == b_tag_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            a_rdy_q <= 1'b0;
            b_rdy_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
            a_rdy_q <= src1_rdy_i || src1_hit;
            b_rdy_q <= use_imm_i || src2_rdy_i || src2_hit;
        end else begin
            if (issue_i) valid_q <= 1'b0;
            if (a_hit) a_rdy_q <= 1'b1;
            if (b_hit) b_rdy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            op_q    <= op_i;
            dst_q   <= dst_i;
            a_tag_q <= src1_tag_i;
            b_tag_q <= op2_i.r.tag;
            a_q     <= src1_hit ? cdb_data_i : src1_val_i;
            if (use_imm_i) begin
                // immediate is sign-extended to the data width
                b_q <= word_t'($signed(op2_i.imm));
            end else begin
                b_q <= src2_hit ? cdb_data_i : src2_val_i;
            end
        end else begin
            if (a_hit) a_q <= cdb_data_i;
            if (b_hit) b_q <= cdb_data_i;
        end
    end

    assign valid_o = valid_q;
    assign ready_o = valid_q && a_rdy_q && b_rdy_q;
    assign op_o    = op_q;
    assign dst_o   = dst_q;
    assign a_o     = a_q;
    assign b_o     = b_q;

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

`include "core_macros.svh"

package isa_pkg;

    import core_pkg::*;

    // integer alu operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // register view of operand 2 with the tag in the low bits
    typedef struct packed {
        logic [15:`TAG_W] pad;
        tag_t             tag;
    } op2_reg_t;

    // operand 2 is either a source tag or a 16-bit immediate
    // and use_imm beside it picks the view
    typedef union packed {
        op2_reg_t    r;
        logic [15:0] imm;
    } op2_field_u;

endpackage

`default_nettype wire

// File: logic/issue_queue.sv
`default_nettype none

`include "core_macros.svh"

module issue_queue
    import core_pkg::*;
    import isa_pkg::*;
#(
    parameter unit_t QUEUE_ID = 1'b0
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       flush_i,
    input  logic       disp_valid_i,
    input  unit_t      disp_unit_i,
    input  alu_op_e    disp_op_i,
    input  tag_t       disp_dst_i,
    input  tag_t       disp_src1_tag_i,
    input  word_t      disp_src1_val_i,
    input  logic       disp_src1_rdy_i,
    input  op2_field_u disp_op2_i,
    input  logic       disp_use_imm_i,
    input  word_t      disp_src2_val_i,
    input  logic       disp_src2_rdy_i,
    output logic       ready_o,
    input  logic       cdb_valid_i,
    input  tag_t       cdb_tag_i,
    input  word_t      cdb_data_i,
    output logic       req_o,
    input  logic       gnt_i,
    output tag_t       res_tag_o,
    output word_t      res_data_o
);

    localparam int IDX_W = $clog2(`IQ_DEPTH);

    logic                 accept;
    logic [`IQ_DEPTH-1:0] ent_valid;
    logic [`IQ_DEPTH-1:0] ent_ready;
    logic [`IQ_DEPTH-1:0] ent_alloc;
    logic [`IQ_DEPTH-1:0] ent_issue;
    alu_op_e              ent_op  [`IQ_DEPTH];
    tag_t                 ent_dst [`IQ_DEPTH];
    word_t                ent_a   [`IQ_DEPTH];
    word_t                ent_b   [`IQ_DEPTH];
    age_t                 age_q   [`IQ_DEPTH];

    logic [IDX_W-1:0]     sel_idx;
    logic                 sel_found;
    age_t                 sel_age;
    logic                 issue_go;
    logic                 issue_fire;

    logic                 iss_valid_q;
    alu_op_e              iss_op_q;
    tag_t                 iss_dst_q;
    word_t                iss_a_q;
    word_t                iss_b_q;
    logic                 iss_move;
    word_t                alu_result;

    logic                 res_valid_q;
    tag_t                 res_tag_q;
    word_t                res_data_q;

    // ------------------------------------------------------------------------
    // allocation of the lowest free entry

    assign accept    = disp_valid_i && (disp_unit_i == QUEUE_ID);
    assign ready_o   = !(&ent_valid);
    assign ent_alloc = accept ? (~ent_valid & (ent_valid + 1'b1)) : '0;

    for (genvar i = 0; i < `IQ_DEPTH; i++) begin : g_entry
        iq_entry u_entry (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .flush_i     (flush_i),
            .alloc_i     (ent_alloc[i]),
            .op_i        (disp_op_i),
            .dst_i       (disp_dst_i),
            .src1_tag_i  (disp_src1_tag_i),
            .src1_val_i  (disp_src1_val_i),
            .src1_rdy_i  (disp_src1_rdy_i),
            .op2_i       (disp_op2_i),
            .use_imm_i   (disp_use_imm_i),
            .src2_val_i  (disp_src2_val_i),
            .src2_rdy_i  (disp_src2_rdy_i),
            .issue_i     (ent_issue[i]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .valid_o     (ent_valid[i]),
            .ready_o     (ent_ready[i]),
            .op_o        (ent_op[i]),
            .dst_o       (ent_dst[i]),
            .a_o         (ent_a[i]),
            .b_o         (ent_b[i])
        );
    end

    // ------------------------------------------------------------------------
    // aging and oldest-ready select

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `IQ_DEPTH; i++) age_q[i] <= '0;
        end else begin
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (flush_i || ent_alloc[i] || ent_issue[i]) begin
                    age_q[i] <= '0;
                end else if (age_q[i] == '0) begin
                    age_q[i] <= age_t'(1);
                end else if (!age_q[i][`AGE_W-1]) begin
                    age_q[i] <= age_q[i] << 1;
                end
            end
        end
    end

    // strict compare keeps ties on the lower index
    always_comb begin
        sel_idx   = '0;
        sel_found = 1'b0;
        sel_age   = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (ent_ready[i] && (!sel_found || age_q[i] > sel_age)) begin
                sel_idx   = IDX_W'(i);
                sel_found = 1'b1;
                sel_age   = age_q[i];
            end
        end
    end

    // stall chain from the result register back to select
    assign iss_move   = iss_valid_q && (!res_valid_q || gnt_i);
    assign issue_go   = !iss_valid_q || iss_move;
    assign issue_fire = sel_found && issue_go;
    assign ent_issue  = issue_fire ? (`IQ_DEPTH'(1) << sel_idx) : '0;

    // ------------------------------------------------------------------------
    // issue register, alu and result register

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss_valid_q <= 1'b0;
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            iss_valid_q <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            if (issue_go) iss_valid_q <= issue_fire;
            if (iss_move) begin
                res_valid_q <= 1'b1;
            end else if (gnt_i) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            iss_op_q  <= ent_op[sel_idx];
            iss_dst_q <= ent_dst[sel_idx];
            iss_a_q   <= ent_a[sel_idx];
            iss_b_q   <= ent_b[sel_idx];
        end
        if (iss_move) begin
            res_tag_q  <= iss_dst_q;
            res_data_q <= alu_result;
        end
    end

    int_alu u_alu (
        .op_i     (iss_op_q),
        .a_i      (iss_a_q),
        .b_i      (iss_b_q),
        .result_o (alu_result)
    );

    assign req_o      = res_valid_q;
    assign res_tag_o  = res_tag_q;
    assign res_data_o = res_data_q;

    // at most one entry leaves per cycle and only one that was ready
    a_issue_single: assert property (@(posedge clk) disable iff (!arst_n_i)
        !flush_i |=> $onehot0($past(ent_valid) & ~ent_valid)
                     && (($past(ent_valid) & ~ent_valid & ~$past(ent_ready)) == '0));

    // the dispatch source must respect ready_o
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n_i)
        accept |-> ready_o);

    // a losing result stays put until granted
    a_res_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_valid_q && !gnt_i && !flush_i
        |=> res_valid_q && $stable(res_tag_q) && $stable(res_data_q));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alu_cluster -f src.f -o sim_alu_cluster

./obj_dir/sim_alu_cluster > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: sim/tb_alu_cluster.sv
`default_nettype none

`include "core_macros.svh"

module tb_alu_cluster
    import core_pkg::*;
    import isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INDEP     = 40;
    localparam int N_HEAVY     = 60;
    localparam int N_GHOST     = 2 * `IQ_DEPTH;
    localparam int N_POST      = 20;
    localparam int N_TOTAL     = N_INDEP + N_HEAVY + N_GHOST + N_POST;
    localparam int CYCLE_LIMIT = 40 * N_TOTAL + 200;
    localparam int N_TAGS      = 1 << `TAG_W;

    logic       clk;
    logic       arst_n_i;
    logic       flush_i;
    logic       disp_valid_i;
    unit_t      disp_unit_i;
    alu_op_e    disp_op_i;
    tag_t       disp_dst_i;
    tag_t       disp_src1_tag_i;
    word_t      disp_src1_val_i;
    logic       disp_src1_rdy_i;
    op2_field_u disp_op2_i;
    logic       disp_use_imm_i;
    word_t      disp_src2_val_i;
    logic       disp_src2_rdy_i;
    logic       iq0_ready_o;
    logic       iq1_ready_o;
    logic       cdb_valid_o;
    tag_t       cdb_tag_o;
    word_t      cdb_data_o;

    // reference model state
    logic [15:0] lfsr_q;
    word_t       tag_val  [N_TAGS];
    logic        pending  [N_TAGS];
    unit_t       tag_unit [N_TAGS];
    int          outstanding [2];
    int          mismatches;
    int          other_errors;
    int          n_bcast;
    int          cycle_count;
    tag_t        ghost_tag;
    logic        ghost_mode;

    alu_cluster uut (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .disp_valid_i    (disp_valid_i),
        .disp_unit_i     (disp_unit_i),
        .disp_op_i       (disp_op_i),
        .disp_dst_i      (disp_dst_i),
        .disp_src1_tag_i (disp_src1_tag_i),
        .disp_src1_val_i (disp_src1_val_i),
        .disp_src1_rdy_i (disp_src1_rdy_i),
        .disp_op2_i      (disp_op2_i),
        .disp_use_imm_i  (disp_use_imm_i),
        .disp_src2_val_i (disp_src2_val_i),
        .disp_src2_rdy_i (disp_src2_rdy_i),
        .iq0_ready_o     (iq0_ready_o),
        .iq1_ready_o     (iq1_ready_o),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_tag_o       (cdb_tag_o),
        .cdb_data_o      (cdb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // random bits and result model

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[14:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[3:0];
            ALU_SRL: return a >> b[3:0];
            default: return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures, %0d broadcasts checked",
                 mismatches, other_errors, n_bcast);
        if (mismatches + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // ------------------------------------------------------------------------
    // per-cycle monitor run on every falling edge

    task automatic observe();
        if (cdb_valid_o) begin
            if (!pending[cdb_tag_o]) begin
                other_errors++;
                $display("error at %0d ns: tag %0d was broadcast while not pending",
                         $time, cdb_tag_o);
            end else begin
                check_value($sformatf("cdb data of tag %0d", cdb_tag_o), cdb_data_o,
                            tag_val[cdb_tag_o]);
                pending[cdb_tag_o] = 1'b0;
                outstanding[tag_unit[cdb_tag_o]]--;
                n_bcast++;
            end
        end
        // fewer outstanding than entries means a free entry
        if (outstanding[0] < `IQ_DEPTH) check_value("iq0 ready level", iq0_ready_o, 1);
        if (outstanding[1] < `IQ_DEPTH) check_value("iq1 ready level", iq1_ready_o, 1);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        disp_valid_i = 1'b0;
        observe();
    endtask

    task automatic drain();
        while (outstanding[0] + outstanding[1] != 0) next_cycle();
    endtask

    task automatic dispatch(input unit_t unit, input logic dep, output logic sent);
        logic [15:0] r;
        logic        found;
        tag_t        dst;
        tag_t        s1;
        tag_t        s2;
        word_t       a_exp;
        word_t       b_exp;
        alu_op_e     op;
        op2_field_u  op2;
        sent  = 1'b0;
        found = 1'b0;
        if (!(unit ? iq1_ready_o : iq0_ready_o)) return;
        r = rand_bits(`TAG_W);
        for (int i = 0; i < N_TAGS && !found; i++) begin
            dst   = tag_t'(r + i);
            found = !pending[dst] && !(ghost_mode && dst == ghost_tag);
        end
        if (!found) return;
        r  = rand_bits(3);
        op = alu_op_e'(r[2:0]);
        s1 = ghost_mode ? ghost_tag : tag_t'(rand_bits(`TAG_W));
        a_exp = tag_val[s1];
        if (ghost_mode) begin
            disp_src1_rdy_i = 1'b0;
        end else if (dep) begin
            // a tag on the cdb right now goes through the capture bypass
            disp_src1_rdy_i = !pending[s1] && !(cdb_valid_o && cdb_tag_o == s1);
        end else begin
            disp_src1_rdy_i = 1'b1;
            a_exp           = rand_bits(16);
        end
        disp_src1_val_i = disp_src1_rdy_i ? a_exp : '0;
        r   = rand_bits(1);
        op2 = '0;
        if (r[0]) begin
            op2.imm         = rand_bits(16);
            b_exp           = op2.imm;
            disp_src2_rdy_i = 1'b0;
        end else begin
            s2        = tag_t'(rand_bits(`TAG_W));
            op2.r.tag = s2;
            b_exp     = tag_val[s2];
            if (dep) begin
                disp_src2_rdy_i = !pending[s2] && !(cdb_valid_o && cdb_tag_o == s2);
            end else begin
                disp_src2_rdy_i = 1'b1;
                b_exp           = rand_bits(16);
            end
        end
        disp_src2_val_i = (!r[0] && disp_src2_rdy_i) ? b_exp : '0;
        disp_use_imm_i  = r[0];
        disp_op2_i      = op2;
        disp_op_i       = op;
        disp_dst_i      = dst;
        disp_src1_tag_i = s1;
        disp_unit_i     = unit;
        disp_valid_i    = 1'b1;
        tag_val[dst]    = alu_model(op, a_exp, b_exp);
        pending[dst]    = 1'b1;
        tag_unit[dst]   = unit;
        outstanding[unit]++;
        sent = 1'b1;
    endtask

    task automatic run_phase(input int count, input logic dep);
        int          done;
        logic        sent;
        logic [15:0] r;
        done = 0;
        while (done < count) begin
            next_cycle();
            r = rand_bits(1);
            dispatch(unit_t'(r[0]), dep, sent);
            if (sent) done++;
        end
    endtask

    // run limit in clock cycles
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errors++;
        $display("error: run timed out after %0d cycles with results still missing",
                 cycle_count);
        finish_run();
    end

    // ------------------------------------------------------------------------
    // test sequence

    initial begin
        logic sent;
        int   k;
        lfsr_q = 16'd88;
        mismatches = 0;
        other_errors = 0;
        n_bcast = 0;
        ghost_mode = 1'b0;
        ghost_tag = '0;
        outstanding[0] = 0;
        outstanding[1] = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            tag_val[t]  = word_t'(t * 16'h0123);
            pending[t]  = 1'b0;
            tag_unit[t] = 1'b0;
        end
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        disp_valid_i = 1'b0;
        disp_unit_i = 1'b0;
        disp_op_i = ALU_ADD;
        disp_dst_i = '0;
        disp_src1_tag_i = '0;
        disp_src1_val_i = '0;
        disp_src1_rdy_i = 1'b0;
        disp_op2_i = '0;
        disp_use_imm_i = 1'b0;
        disp_src2_val_i = '0;
        disp_src2_rdy_i = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // idle after reset
        repeat (4) begin
            next_cycle();
            check_value("iq0 ready after reset", iq0_ready_o, 1);
            check_value("iq1 ready after reset", iq1_ready_o, 1);
            check_value("cdb valid before dispatch", cdb_valid_o, 0);
        end

        run_phase(N_INDEP, 1'b0);
        drain();
        run_phase(N_HEAVY, 1'b1);
        drain();

        // fill both queues behind a tag that never arrives
        ghost_tag  = tag_t'(rand_bits(`TAG_W));
        ghost_mode = 1'b1;
        k = 0;
        while (k < N_GHOST) begin
            next_cycle();
            dispatch(unit_t'(k % 2), 1'b1, sent);
            if (sent) k++;
        end
        repeat (8) begin
            next_cycle();
            check_value("iq0 ready when full", iq0_ready_o, outstanding[0] < `IQ_DEPTH);
            check_value("iq1 ready when full", iq1_ready_o, outstanding[1] < `IQ_DEPTH);
        end

        next_cycle();
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        for (int t = 0; t < N_TAGS; t++) pending[t] = 1'b0;
        outstanding[0] = 0;
        outstanding[1] = 0;
        ghost_mode = 1'b0;
        repeat (6) begin
            next_cycle();
            check_value("iq0 ready after flush", iq0_ready_o, 1);
            check_value("iq1 ready after flush", iq1_ready_o, 1);
        end

        run_phase(N_POST, 1'b1);
        drain();
        finish_run();
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/core_pkg.sv
logic/isa_pkg.sv
logic/int_alu.sv
logic/iq_entry.sv
logic/issue_queue.sv
logic/cdb_arbiter.sv
logic/alu_cluster.sv
sim/tb_alu_cluster.sv
